//--- controlSelect.sv
`timescale 1ns/1ns

module controlSelect
    import ctrlPkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    input  logic   instrValid,
    input  decodeT special,
    input  decodeT extended,
    output ctrlT   ctrl,
    output logic   illegal,
    output logic   ctrlValid
);

    ctrlT nextCtrl;
    logic anyHit;

    ////////////////////////////////////////////////////////////////////
    // merge
    ////////////////////////////////////////////////////////////////////

    assign anyHit = special.hit | extended.hit;

    // unknown words fall through to the inactive word
    always_comb begin
        if (special.hit) begin
            nextCtrl = special.ctrl;
        end else if (extended.hit) begin
            nextCtrl = extended.ctrl;
        end else begin
            nextCtrl = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
            illegal   <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
            // hold last word while idle
            if (instrValid) begin
                ctrl    <= nextCtrl;
                illegal <= !anyHit;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    // the two opcode spaces are disjoint
    assert property (@(posedge Clk) disable iff (!arstN)
        instrValid |-> !(special.hit && extended.hit))
        else $error("controlSelect: both decoders hit");

endmodule

//--- controller.sv
`timescale 1ns/1ns

module controller
    import ctrlPkg::*;
(
    input  logic  Clk,
    input  logic  arstN,
    input  logic  instrValid,
    input  instrU instr,
    output ctrlT  ctrl,
    output logic  illegal,
    output logic  ctrlValid
);

    decodeT specialResult;
    decodeT extendedResult;

    // opcode 000000
    specialDecoder uSpecial (
        .instr  (instr),
        .result (specialResult)
    );

    // SPECIAL2, SPECIAL3 and immediates
    extendedDecoder uExtended (
        .instr  (instr),
        .result (extendedResult)
    );

    controlSelect uSelect (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .special    (specialResult),
        .extended   (extendedResult),
        .ctrl       (ctrl),
        .illegal    (illegal),
        .ctrlValid  (ctrlValid)
    );

endmodule

//--- ctrlPkg.sv
package ctrlPkg;

    ////////////////////////////////////////////////////////////////////
    // opcode field, instruction bits 31:26
    ////////////////////////////////////////////////////////////////////

    // register forms
    localparam logic [5:0] opSpecial  = 6'b000000;
    localparam logic [5:0] opSpecial2 = 6'b011100;
    localparam logic [5:0] opSpecial3 = 6'b011111;

    // immediate forms
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opAddiu    = 6'b001001;
    localparam logic [5:0] opSlti     = 6'b001010;
    localparam logic [5:0] opSltiu    = 6'b001011;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;

    ////////////////////////////////////////////////////////////////////
    // function field, instruction bits 5:0
    ////////////////////////////////////////////////////////////////////

    // SPECIAL, shifts by shamt
    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnSrl   = 6'b000010;
    localparam logic [5:0] fnSra   = 6'b000011;

    // SPECIAL, shifts by rs
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrlv  = 6'b000110;
    localparam logic [5:0] fnSrav  = 6'b000111;

    // SPECIAL, conditional moves and HI/LO multiplies
    localparam logic [5:0] fnMovz  = 6'b001010;
    localparam logic [5:0] fnMovn  = 6'b001011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;

    // SPECIAL, arithmetic and logic
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    // SPECIAL2
    localparam logic [5:0] fnMadd  = 6'b000000;
    localparam logic [5:0] fnMul   = 6'b000010;
    localparam logic [5:0] fnMsub  = 6'b000100;

    ////////////////////////////////////////////////////////////////////
    // control word
    ////////////////////////////////////////////////////////////////////

    // codes are fixed by the ALU, gaps are intentional
    typedef enum logic [5:0] {
        aluAdd   = 6'b000000,
        aluSub   = 6'b000001,
        aluMul   = 6'b000010,
        aluMult  = 6'b000011,
        aluMadd  = 6'b000100,
        aluMsub  = 6'b000101,
        aluAnd   = 6'b001111,
        aluOr    = 6'b010000,
        aluNor   = 6'b010001,
        aluXor   = 6'b010010,
        aluSeh   = 6'b010011,
        aluSll   = 6'b010100,
        aluSrl   = 6'b010101,
        aluMovn  = 6'b010110,
        aluMovz  = 6'b010111,
        aluRotr  = 6'b011000,
        aluSra   = 6'b011001,
        aluSeb   = 6'b011010,
        aluSlt   = 6'b011011,
        aluAddu  = 6'b100000,
        aluMultu = 6'b100001,
        aluSltu  = 6'b100010
    } aluOpT;

    // all zero means nothing written, add on rs/rt
    typedef struct packed {
        logic  aluSrc;
        logic  regDst;
        logic  regWrite;
        logic  aluSft;
        aluOpT aluOp;
    } ctrlT;

    // one decoder's answer
    typedef struct packed {
        logic hit;
        ctrlT ctrl;
    } decodeT;

    ////////////////////////////////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtT;

    // same 32 bits, register or immediate view
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrU;

endpackage

//--- extendedDecoder.sv
`timescale 1ns/1ns

module extendedDecoder
    import ctrlPkg::*;
(
    input  instrU  instr,
    output decodeT result
);

    logic immOp;

    assign immOp = instr.iFmt.opcode inside
                   {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};

    always_comb begin
        result = '0;
        case (instr.iFmt.opcode)
            ////////////////////////////////////////////////////////////////////
            // SPECIAL2, multiply family
            ////////////////////////////////////////////////////////////////////
            opSpecial2: begin
                case (instr.rFmt.funct)
                    fnMul: begin
                        result.hit           = 1'b1;
                        result.ctrl.regDst   = 1'b1;
                        result.ctrl.regWrite = 1'b1;
                        result.ctrl.aluOp    = aluMul;
                    end
                    // accumulate into HI/LO only
                    fnMadd: begin
                        result.hit         = 1'b1;
                        result.ctrl.aluOp  = aluMadd;
                    end
                    fnMsub: begin
                        result.hit         = 1'b1;
                        result.ctrl.aluOp  = aluMsub;
                    end
                    default: result = '0;
                endcase
            end

            ////////////////////////////////////////////////////////////////////
            // SPECIAL3, sign extension
            ////////////////////////////////////////////////////////////////////
            opSpecial3: begin
                result.hit           = 1'b1;
                result.ctrl.regDst   = 1'b1;
                result.ctrl.regWrite = 1'b1;
                // shamt[3] is instruction bit 9
                if (instr.rFmt.shamt[3]) begin
                    result.ctrl.aluOp = aluSeh;
                end else begin
                    result.ctrl.aluOp = aluSeb;
                end
            end

            ////////////////////////////////////////////////////////////////////
            // immediates, flags set below
            ////////////////////////////////////////////////////////////////////
            opAddi:  result.ctrl.aluOp = aluAdd;
            opAddiu: result.ctrl.aluOp = aluAddu;
            opSlti:  result.ctrl.aluOp = aluSlt;
            opSltiu: result.ctrl.aluOp = aluSltu;
            opAndi:  result.ctrl.aluOp = aluAnd;
            opOri:   result.ctrl.aluOp = aluOr;
            opXori:  result.ctrl.aluOp = aluXor;

            // opcode 000000 belongs to the other decoder
            default: result = '0;
        endcase

        // immediate replaces rt, result lands in rt
        if (immOp) begin
            result.hit           = 1'b1;
            result.ctrl.aluSrc   = 1'b1;
            result.ctrl.regWrite = 1'b1;
        end
    end

    always_comb begin
        assert (!(result.ctrl.aluSrc && result.ctrl.regDst))
            else $error("extendedDecoder: immediate form with rd destination");
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbController -o simController
./obj_dir/simController | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    exit 1
fi

//--- sources.f
+incdir+.
ctrlPkg.sv
specialDecoder.sv
extendedDecoder.sv
controlSelect.sv
controller.sv
tbController.sv

//--- specialDecoder.sv
`timescale 1ns/1ns

module specialDecoder
    import ctrlPkg::*;
(
    input  instrU  instr,
    output decodeT result
);

    logic shiftFunct;
    logic shiftForm;

    // sll, srl and sra only exist with rs[4:1] clear
    assign shiftFunct = instr.rFmt.funct inside {fnSll, fnSrl, fnSra};
    assign shiftForm  = (instr.rFmt.rs[4:1] == 4'b0000);

    always_comb begin
        result = '0;
        if (instr.rFmt.opcode == opSpecial) begin
            // most of the group writes rd
            result.hit           = 1'b1;
            result.ctrl.regDst   = 1'b1;
            result.ctrl.regWrite = 1'b1;

            case (instr.rFmt.funct)
                // shift amount from shamt
                fnSll: begin
                    result.ctrl.aluOp  = aluSll;
                    result.ctrl.aluSft = 1'b1;
                end
                fnSrl: begin
                    result.ctrl.aluSft = 1'b1;
                    // rs[0] turns srl into rotr
                    if (instr.rFmt.rs[0]) begin
                        result.ctrl.aluOp = aluRotr;
                    end else begin
                        result.ctrl.aluOp = aluSrl;
                    end
                end
                fnSra: begin
                    result.ctrl.aluOp  = aluSra;
                    result.ctrl.aluSft = 1'b1;
                end

                // shift amount from rs
                fnSllv: result.ctrl.aluOp = aluSll;
                fnSrlv: begin
                    // shamt[0] turns srlv into rotrv
                    if (instr.rFmt.shamt[0]) begin
                        result.ctrl.aluOp = aluRotr;
                    end else begin
                        result.ctrl.aluOp = aluSrl;
                    end
                end
                fnSrav: result.ctrl.aluOp = aluSra;

                // write decided by rt
                fnMovz: begin
                    result.ctrl.aluOp    = aluMovz;
                    result.ctrl.regWrite = (instr.rFmt.rt == 5'd0);
                end
                fnMovn: begin
                    result.ctrl.aluOp    = aluMovn;
                    result.ctrl.regWrite = (instr.rFmt.rt != 5'd0);
                end

                // result goes to HI/LO, no register write
                fnMult: begin
                    result.ctrl.aluOp    = aluMult;
                    result.ctrl.regDst   = 1'b0;
                    result.ctrl.regWrite = 1'b0;
                end
                fnMultu: begin
                    result.ctrl.aluOp    = aluMultu;
                    result.ctrl.regDst   = 1'b0;
                    result.ctrl.regWrite = 1'b0;
                end

                fnAdd:  result.ctrl.aluOp = aluAdd;
                fnAddu: result.ctrl.aluOp = aluAddu;
                fnSub:  result.ctrl.aluOp = aluSub;
                fnAnd:  result.ctrl.aluOp = aluAnd;
                fnOr:   result.ctrl.aluOp = aluOr;
                fnXor:  result.ctrl.aluOp = aluXor;
                fnNor:  result.ctrl.aluOp = aluNor;
                fnSlt:  result.ctrl.aluOp = aluSlt;
                fnSltu: result.ctrl.aluOp = aluSltu;

                // HI/LO moves and the rest are not ours
                default: result = '0;
            endcase

            if (shiftFunct && !shiftForm) begin
                result = '0;
            end
        end

        // nop, known but inactive
        if (instr == '0) begin
            result     = '0;
            result.hit = 1'b1;
        end
    end

    // only mult/multu/movx leave rd unwritten; nothing here targets rt
    always_comb begin
        if (result.hit) begin
            assert (!result.ctrl.regWrite || result.ctrl.regDst)
                else $error("specialDecoder: regWrite without regDst");
        end
    end

endmodule

//--- tbExpect.svh
`ifndef tbExpectSvh
`define tbExpectSvh

// illegal flag next to the expected control word
typedef struct packed {
    logic illegal;
    ctrlT ctrl;
} expectT;

// fields: aluSrc, regDst, regWrite, aluSft, aluOp
function automatic ctrlT rdWrite(input aluOpT op);
    return ctrlT'{1'b0, 1'b1, 1'b1, 1'b0, op};
endfunction

function automatic ctrlT shiftByShamt(input aluOpT op);
    return ctrlT'{1'b0, 1'b1, 1'b1, 1'b1, op};
endfunction

// result stays in HI/LO
function automatic ctrlT hiLoOnly(input aluOpT op);
    return ctrlT'{1'b0, 1'b0, 1'b0, 1'b0, op};
endfunction

function automatic ctrlT immToRt(input aluOpT op);
    return ctrlT'{1'b1, 1'b0, 1'b1, 1'b0, op};
endfunction

function automatic expectT expectDecode(input instrU w);
    expectT     e;
    logic [5:0] fn;
    e  = '0;
    fn = w.rFmt.funct;
    case (w.rFmt.opcode)
        opSpecial: begin
            case (fn)
                fnSll, fnSrl, fnSra: begin
                    // shamt forms need rs[4:1] clear
                    if (w.rFmt.rs[4:1] != 4'd0) begin
                        e.illegal = 1'b1;
                    end else if (fn == fnSll) begin
                        e.ctrl = shiftByShamt(aluSll);
                    end else if (fn == fnSra) begin
                        e.ctrl = shiftByShamt(aluSra);
                    end else begin
                        e.ctrl = shiftByShamt(w.rFmt.rs[0] ? aluRotr : aluSrl);
                    end
                end
                fnSllv: e.ctrl = rdWrite(aluSll);
                fnSrlv: e.ctrl = rdWrite(w.rFmt.shamt[0] ? aluRotr : aluSrl);
                fnSrav: e.ctrl = rdWrite(aluSra);
                fnMovn: begin
                    e.ctrl          = rdWrite(aluMovn);
                    e.ctrl.regWrite = (w.rFmt.rt != 5'd0);
                end
                fnMovz: begin
                    e.ctrl          = rdWrite(aluMovz);
                    e.ctrl.regWrite = (w.rFmt.rt == 5'd0);
                end
                fnMult:  e.ctrl = hiLoOnly(aluMult);
                fnMultu: e.ctrl = hiLoOnly(aluMultu);
                fnAdd:   e.ctrl = rdWrite(aluAdd);
                fnAddu:  e.ctrl = rdWrite(aluAddu);
                fnSub:   e.ctrl = rdWrite(aluSub);
                fnAnd:   e.ctrl = rdWrite(aluAnd);
                fnOr:    e.ctrl = rdWrite(aluOr);
                fnXor:   e.ctrl = rdWrite(aluXor);
                fnNor:   e.ctrl = rdWrite(aluNor);
                fnSlt:   e.ctrl = rdWrite(aluSlt);
                fnSltu:  e.ctrl = rdWrite(aluSltu);
                default: e.illegal = 1'b1;
            endcase
        end
        opSpecial2: begin
            case (fn)
                fnMul:   e.ctrl = rdWrite(aluMul);
                fnMadd:  e.ctrl = hiLoOnly(aluMadd);
                fnMsub:  e.ctrl = hiLoOnly(aluMsub);
                default: e.illegal = 1'b1;
            endcase
        end
        opSpecial3: e.ctrl = rdWrite(w.rFmt.shamt[3] ? aluSeh : aluSeb);
        opAddi:  e.ctrl = immToRt(aluAdd);
        opAddiu: e.ctrl = immToRt(aluAddu);
        opSlti:  e.ctrl = immToRt(aluSlt);
        opSltiu: e.ctrl = immToRt(aluSltu);
        opAndi:  e.ctrl = immToRt(aluAnd);
        opOri:   e.ctrl = immToRt(aluOr);
        opXori:  e.ctrl = immToRt(aluXor);
        default: e.illegal = 1'b1;
    endcase
    // nop is known but does nothing
    if (w == '0) begin
        e = '0;
    end
    return e;
endfunction

`endif

//--- tbController.sv
`timescale 1ns/1ns

module tbController
    import ctrlPkg::*;
();

    logic   Clk;
    logic   arstN;
    logic   instrValid;
    instrU  instr;
    ctrlT   ctrl;
    logic   illegal;
    logic   ctrlValid;

    `include "tbExpect.svh"

    instrU  histWord;
    expectT histExp;
    logic   histValid;
    integer seed = 22940;
    int     errors = 0;
    int     testCount = 0;
    int     testFails = 0;
    int     startErrors = 0;
    int     timeoutCycles = 20;

    logic [5:0] regFns [13] = '{fnAdd, fnAddu, fnSub, fnAnd, fnOr, fnNor, fnXor,
                                fnSllv, fnSrav, fnSlt, fnSltu, fnMult, fnMultu};
    logic [5:0] immOps [7]  = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};
    logic [5:0] mulFns [3]  = '{fnMul, fnMadd, fnMsub};

    controller DUT (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrl       (ctrl),
        .illegal    (illegal),
        .ctrlValid  (ctrlValid)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////////////
    // one-entry history and output checks
    ////////////////////////////////////////////////////////////////////

    always @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            histWord  <= '0;
            histExp   <= '0;
            histValid <= 1'b0;
        end else begin
            histValid <= instrValid;
            if (instrValid) begin
                histWord <= instr;
                histExp  <= expectDecode(instr);
            end
        end
    end

    assert property (@(posedge Clk) disable iff (!arstN)
        ctrl == histExp.ctrl && illegal == histExp.illegal)
        else begin
            errors = errors + 1;
            $display("Fail %0t: ctrl %h illegal %b, expected %h %b for word %h", $time,
                     ctrl, illegal, histExp.ctrl, histExp.illegal, histWord);
        end

    assert property (@(posedge Clk) disable iff (!arstN) ctrlValid == histValid)
        else begin
            errors = errors + 1;
            $display("Fail %0t: ctrlValid %b, expected %b", $time, ctrlValid, histValid);
        end

    ////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    function automatic instrU buildRWord(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic instrU buildIWord(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic driveWord(input instrU w);
        instr      = w;
        instrValid = 1'b1;
        @(posedge Clk);
        #1;
    endtask

    task automatic waitResult();
        int cycles;
        cycles     = 0;
        instrValid = 1'b0;
        while (!ctrlValid && cycles < timeoutCycles) begin
            @(posedge Clk);
            #1;
            cycles++;
        end
        if (!ctrlValid) begin
            errors = errors + 1;
            $display("Timeout: ctrlValid did not rise within %0d cycles", timeoutCycles);
        end else begin
            // the result is checked on this edge
            @(posedge Clk);
            #1;
        end
    endtask

    task automatic sendWord(input instrU w);
        driveWord(w);
        waitResult();
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errors != startErrors) begin
            testFails++;
            $display("test %s: %0d errors", name, errors - startErrors);
        end else begin
            $display("test %s: ok", name);
        end
        startErrors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        instrValid = 1'b0;
        instr      = '0;
        arstN      = 1'b0;
        repeat (16) @(posedge Clk);
        #1;
        arstN = 1'b1;
        repeat (3) @(posedge Clk);
        #1;
        reportTest("reset");

        for (int i = 0; i < 13; i++) begin
            r = nextRand();
            sendWord(buildRWord(opSpecial, r[4:0], r[9:5], r[14:10], r[19:15], regFns[i]));
        end
        for (int i = 0; i < 2; i++) begin
            r = nextRand();
            // srl/rotr, srlv/rotrv and seb/seh splits
            sendWord(buildRWord(opSpecial, {4'd0, i[0]}, r[9:5], r[14:10], r[19:15], fnSrl));
            sendWord(buildRWord(opSpecial, {4'd0, i[0]}, r[9:5], r[14:10], r[19:15], fnSll));
            sendWord(buildRWord(opSpecial, {4'd0, i[0]}, r[9:5], r[14:10], r[19:15], fnSra));
            sendWord(buildRWord(opSpecial, r[4:0], r[9:5], r[14:10], {r[19:16], i[0]}, fnSrlv));
            sendWord(buildRWord(opSpecial3, 5'd0, r[9:5], r[14:10], {1'b1, i[0], 3'd0},
                                6'b100000));
        end
        for (int i = 0; i < 3; i++) begin
            r = nextRand();
            sendWord(buildRWord(opSpecial2, r[4:0], r[9:5], r[14:10], 5'd0, mulFns[i]));
        end
        reportTest("register");

        for (int i = 0; i < 2; i++) begin
            r = nextRand();
            sendWord(buildRWord(opSpecial, r[4:0], i ? {r[9:6], 1'b1} : 5'd0, r[14:10], 5'd0,
                                fnMovn));
            sendWord(buildRWord(opSpecial, r[4:0], i ? {r[9:6], 1'b1} : 5'd0, r[14:10], 5'd0,
                                fnMovz));
        end
        reportTest("movx");

        for (int i = 0; i < 7; i++) begin
            r = nextRand();
            sendWord(buildIWord(immOps[i], r[4:0], r[9:5], r[31:16]));
        end
        reportTest("immediate");

        // consecutive words, illegal ones mixed in
        r = nextRand();
        driveWord(buildIWord(opAddi, r[4:0], r[9:5], r[31:16]));
        driveWord(buildRWord(opSpecial, r[4:0], 5'd0, r[14:10], 5'd0, fnMovn));
        driveWord(buildRWord(opSpecial3, 5'd0, r[9:5], r[14:10], 5'b11000, 6'b100000));
        driveWord(buildRWord(opSpecial, 5'd0, 5'd0, r[14:10], 5'd0, 6'b010000));
        driveWord(buildIWord(opOri, r[4:0], r[9:5], r[31:16]));
        driveWord('0);
        driveWord(buildIWord(6'b100011, r[4:0], r[9:5], r[31:16]));
        driveWord(buildRWord(opSpecial, 5'b00110, r[9:5], r[14:10], r[19:15], fnSll));
        driveWord(buildRWord(opSpecial2, r[4:0], r[9:5], r[14:10], 5'd0, 6'b111111));
        driveWord(buildRWord(opSpecial, r[4:0], r[9:5], r[14:10], 5'd0, fnSub));
        waitResult();
        reportTest("stream");

        $display("tests %0d, failed %0d, errors %0d", testCount, testFails, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
